// File: include/mips_config.svh
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// --------------------
// Sizes
// --------------------
`define DATA_W      32      // Data path width
`define REG_N       32      // Register file entries
`define DMEM_WORDS  64      // Data memory depth in words

// --------------------
// Opcodes in instr[31:26]
// --------------------
`define OP_RTYPE    6'h00
`define OP_ADDI     6'h08
`define OP_LW       6'h23
`define OP_SW       6'h2b

// R-type function codes in instr[5:0]
`define FN_SRA      6'h03
`define FN_ADD      6'h20
`define FN_SUB      6'h22
`define FN_AND      6'h24
`define FN_OR       6'h25
`define FN_XOR      6'h26
`define FN_NOR      6'h27
`define FN_SLT      6'h2a
`define FN_MUL      6'h18
`define FN_DIV      6'h1a

`endif

// File: rtl/mips_pkg.sv
`default_nettype none

`include "mips_config.svh"

package mips_pkg;

	// --------------------
	// Vector types
	// --------------------
	typedef logic [`DATA_W-1:0] word_t;   // One data word
	typedef logic [31:0]        instr_t;  // Raw instruction
	typedef logic [4:0]         reg_idx_t; // Register number

	// ALU operation
	typedef enum logic [3:0] {
		alu_add = 4'h0,
		alu_sub = 4'h1,
		alu_and = 4'h2,
		alu_or  = 4'h3,
		alu_xor = 4'h4,
		alu_nor = 4'h5,
		alu_slt = 4'h6,
		alu_mul = 4'h7,
		alu_div = 4'h8,
		alu_sra = 4'h9,
		alu_bad = 4'hf  // Unknown funct gives 0
	} alu_op_t;

	// Decoded ALU class
	typedef enum logic {
		class_add   = 1'b0, // addi, lw, sw
		class_funct = 1'b1  // R-type by funct
	} alu_class_t;

	// Operand source
	typedef enum logic [1:0] {
		fwd_reg = 2'd0, // Value read in decode
		fwd_wb  = 2'd1, // From MEM/WB
		fwd_mem = 2'd2  // From EX/MEM
	} fwd_sel_t;

endpackage

`default_nettype wire

// File: rtl/decode_stage.sv
`default_nettype none

`include "mips_config.svh"

module decode_stage
	import mips_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  instr_t     instr,
	input  logic       instr_valid,
	input  logic       wb_en,        // Register file write port
	input  reg_idx_t   wb_reg,
	input  word_t      wb_data,
	output reg_idx_t   ex_rs,
	output reg_idx_t   ex_rt,
	output reg_idx_t   ex_rd,
	output word_t      ex_data_1,
	output word_t      ex_data_2,
	output word_t      ex_imm,
	output logic [5:0] ex_funct,
	output alu_class_t ex_class,
	output logic       ex_use_imm,
	output logic       ex_dst_rd,
	output logic       ex_mem_read,
	output logic       ex_mem_write,
	output logic       ex_reg_write
);

	// Instruction fields
	logic [5:0] opcode;
	reg_idx_t   rs, rt, rd;
	word_t      imm_sx;

	word_t      regs [`REG_N];
	word_t      rd_data_1, rd_data_2;

	// Decoded controls
	alu_class_t d_class;
	logic       d_use_imm, d_dst_rd, d_mem_read, d_mem_write, d_reg_write;

	assign opcode = instr[31:26];
	assign rs     = instr[25:21];
	assign rt     = instr[20:16];
	assign rd     = instr[15:11];
	assign imm_sx = {{(`DATA_W-16){instr[15]}}, instr[15:0]}; // Sign extend

	// --------------------
	// Register file
	// --------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < `REG_N; i++)
				regs[i] <= '0;
		end
		else if (wb_en && wb_reg != '0)
			regs[wb_reg] <= wb_data; // r0 never written
	end

	// Reads with same-cycle write-through
	always_comb
	begin
		if (rs == '0)
			rd_data_1 = '0;
		else if (wb_en && wb_reg == rs)
			rd_data_1 = wb_data;
		else
			rd_data_1 = regs[rs];

		if (rt == '0)
			rd_data_2 = '0;
		else if (wb_en && wb_reg == rt)
			rd_data_2 = wb_data;
		else
			rd_data_2 = regs[rt];
	end

	// --------------------
	// Control decode
	// --------------------
	always_comb
	begin
		d_class     = class_add;
		d_use_imm   = 1'b0;
		d_dst_rd    = 1'b0;
		d_mem_read  = 1'b0;
		d_mem_write = 1'b0;
		d_reg_write = 1'b0;
		if (instr_valid)
		begin
			case (opcode)
				`OP_RTYPE:
				begin
					d_class     = class_funct;
					d_dst_rd    = 1'b1;      // Write rd
					d_reg_write = 1'b1;
				end
				`OP_ADDI:
				begin
					d_use_imm   = 1'b1;
					d_reg_write = 1'b1;
				end
				`OP_LW:
				begin
					d_use_imm   = 1'b1;      // Address = rs + imm
					d_mem_read  = 1'b1;
					d_reg_write = 1'b1;
				end
				`OP_SW:
				begin
					d_use_imm   = 1'b1;
					d_mem_write = 1'b1;
				end
				default: ;                   // Unknown opcode is a bubble
			endcase
		end
	end

	// ID/EX register
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			ex_rs        <= '0;
			ex_rt        <= '0;
			ex_rd        <= '0;
			ex_data_1    <= '0;
			ex_data_2    <= '0;
			ex_imm       <= '0;
			ex_funct     <= '0;
			ex_class     <= class_add;
			ex_use_imm   <= 1'b0;
			ex_dst_rd    <= 1'b0;
			ex_mem_read  <= 1'b0;
			ex_mem_write <= 1'b0;
			ex_reg_write <= 1'b0;
		end
		else
		begin
			ex_rs        <= rs;
			ex_rt        <= rt;
			ex_rd        <= rd;
			ex_data_1    <= rd_data_1;
			ex_data_2    <= rd_data_2;
			ex_imm       <= imm_sx;
			ex_funct     <= instr[5:0];
			ex_class     <= d_class;
			ex_use_imm   <= d_use_imm;
			ex_dst_rd    <= d_dst_rd;
			ex_mem_read  <= d_mem_read;
			ex_mem_write <= d_mem_write;
			ex_reg_write <= d_reg_write;
		end
	end

endmodule

`default_nettype wire

// File: rtl/execute_stage.sv
`default_nettype none

`include "mips_config.svh"

module execute_stage
	import mips_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       flush,          // Kill instruction in EX
	input  reg_idx_t   ex_rs,
	input  reg_idx_t   ex_rt,
	input  reg_idx_t   ex_rd,
	input  word_t      ex_data_1,
	input  word_t      ex_data_2,
	input  word_t      ex_imm,
	input  logic [5:0] ex_funct,
	input  alu_class_t ex_class,
	input  logic       ex_use_imm,
	input  logic       ex_dst_rd,
	input  logic       ex_mem_read,
	input  logic       ex_mem_write,
	input  logic       ex_reg_write,
	input  logic       wb_en,
	input  reg_idx_t   wb_reg,
	input  word_t      wb_data,
	output word_t      mem_res,
	output word_t      mem_store_data,
	output reg_idx_t   mem_dst,
	output logic       mem_mem_read,
	output logic       mem_mem_write,
	output logic       mem_reg_write
);

	alu_op_t  alu_op;
	fwd_sel_t fwd_a, fwd_b;
	word_t    rs_val, rt_val;  // Forwarded register values
	word_t    op_1, op_2;
	word_t    alu_res;
	reg_idx_t dst;

	// --------------------
	// ALU control
	// --------------------
	always_comb
	begin
		alu_op = alu_add; // addi, lw, sw
		if (ex_class == class_funct)
		begin
			case (ex_funct)
				`FN_SRA: alu_op = alu_sra;
				`FN_ADD: alu_op = alu_add;
				`FN_SUB: alu_op = alu_sub;
				`FN_AND: alu_op = alu_and;
				`FN_OR:  alu_op = alu_or;
				`FN_XOR: alu_op = alu_xor;
				`FN_NOR: alu_op = alu_nor;
				`FN_SLT: alu_op = alu_slt;
				`FN_MUL: alu_op = alu_mul;
				`FN_DIV: alu_op = alu_div;
				default: alu_op = alu_bad;
			endcase
		end
	end

	// --------------------
	// Forwarding
	// --------------------
	// EX/MEM wins over MEM/WB as it holds the younger result
	assign fwd_a = (mem_reg_write && mem_dst != '0 && mem_dst == ex_rs) ? fwd_mem :
	               (wb_en && wb_reg != '0 && wb_reg == ex_rs)            ? fwd_wb  :
	                                                                       fwd_reg;
	assign fwd_b = (mem_reg_write && mem_dst != '0 && mem_dst == ex_rt) ? fwd_mem :
	               (wb_en && wb_reg != '0 && wb_reg == ex_rt)            ? fwd_wb  :
	                                                                       fwd_reg;

	always_comb
	begin
		case (fwd_a)
			fwd_mem: rs_val = mem_res;
			fwd_wb:  rs_val = wb_data;
			default: rs_val = ex_data_1;
		endcase
		case (fwd_b)
			fwd_mem: rt_val = mem_res;
			fwd_wb:  rt_val = wb_data;
			default: rt_val = ex_data_2;
		endcase
	end

	assign op_1 = rs_val;
	assign op_2 = ex_use_imm ? ex_imm : rt_val; // Immediate for I-type
	assign dst  = ex_dst_rd ? ex_rd : ex_rt;     // rd for R-type

	// --------------------
	// ALU
	// --------------------
	always_comb
	begin
		case (alu_op)
			alu_add: alu_res = op_1 + op_2;
			alu_sub: alu_res = op_1 - op_2;
			alu_and: alu_res = op_1 & op_2;
			alu_or:  alu_res = op_1 | op_2;
			alu_xor: alu_res = op_1 ^ op_2;
			alu_nor: alu_res = ~(op_1 | op_2);
			alu_slt: alu_res = {{(`DATA_W-1){1'b0}}, op_1 < op_2}; // Unsigned compare
			alu_mul: alu_res = op_1 * op_2;                        // Low word only
			alu_div: alu_res = (op_2 == '0) ? '1 : op_1 / op_2;    // x/0 gives all ones
			alu_sra: alu_res = $signed(op_2) >>> op_1[4:0];        // Shift rt by rs
			default: alu_res = '0;
		endcase
	end

	// EX/MEM register where flush drops the side effects
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			mem_mem_read  <= 1'b0;
			mem_mem_write <= 1'b0;
			mem_reg_write <= 1'b0;
		end
		else
		begin
			mem_mem_read  <= ex_mem_read  & ~flush;
			mem_mem_write <= ex_mem_write & ~flush;
			mem_reg_write <= ex_reg_write & ~flush;
		end
	end

	// Payload
	always_ff @(posedge clk)
	begin
		mem_res        <= alu_res;
		mem_store_data <= rt_val;  // Store data is the forwarded rt
		mem_dst        <= dst;
	end

endmodule

`default_nettype wire

// File: rtl/result_stage.sv
`default_nettype none

`include "mips_config.svh"

module result_stage
	import mips_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  word_t    mem_res,        // ALU result and memory address
	input  word_t    mem_store_data,
	input  reg_idx_t mem_dst,
	input  logic     mem_mem_read,
	input  logic     mem_mem_write,
	input  logic     mem_reg_write,
	output logic     wb_en,
	output reg_idx_t wb_reg,
	output word_t    wb_data
);

	localparam int IDX_W = $clog2(`DMEM_WORDS);

	word_t             dmem [`DMEM_WORDS];
	logic [IDX_W-1:0]  dmem_idx;
	word_t             load_data;

	assign dmem_idx  = mem_res[IDX_W+1:2]; // Word address without byte offset
	assign load_data = dmem[dmem_idx];     // Async read

	// --------------------
	// Data memory
	// --------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < `DMEM_WORDS; i++)
				dmem[i] <= '0;
		end
		else if (mem_mem_write)
			dmem[dmem_idx] <= mem_store_data;
	end

	// MEM/WB register
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			wb_en <= 1'b0;
		else
			wb_en <= mem_reg_write;
	end

	always_ff @(posedge clk)
	begin
		wb_reg  <= mem_dst;
		wb_data <= mem_mem_read ? load_data : mem_res; // Writeback select
	end

endmodule

`default_nettype wire

// File: rtl/mips_core.sv
`default_nettype none

module mips_core
	import mips_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  instr_t   instr,
	input  logic     instr_valid,   // Low slot becomes a bubble
	input  logic     flush,
	output logic     wb_en,
	output reg_idx_t wb_reg,
	output word_t    wb_data
);

	// --------------------
	// ID/EX
	// --------------------
	reg_idx_t   ex_rs, ex_rt, ex_rd;
	word_t      ex_data_1, ex_data_2, ex_imm;
	logic [5:0] ex_funct;
	alu_class_t ex_class;
	logic       ex_use_imm, ex_dst_rd;
	logic       ex_mem_read, ex_mem_write, ex_reg_write;

	// EX/MEM
	word_t      mem_res, mem_store_data;
	reg_idx_t   mem_dst;
	logic       mem_mem_read, mem_mem_write, mem_reg_write;

	decode_stage u_decode (
		.clk, .rst_n, .instr, .instr_valid,
		.wb_en, .wb_reg, .wb_data,            // Writeback into register file
		.ex_rs, .ex_rt, .ex_rd, .ex_data_1, .ex_data_2, .ex_imm, .ex_funct,
		.ex_class, .ex_use_imm, .ex_dst_rd,
		.ex_mem_read, .ex_mem_write, .ex_reg_write
	);

	execute_stage u_execute (
		.clk, .rst_n, .flush,
		.ex_rs, .ex_rt, .ex_rd, .ex_data_1, .ex_data_2, .ex_imm, .ex_funct,
		.ex_class, .ex_use_imm, .ex_dst_rd,
		.ex_mem_read, .ex_mem_write, .ex_reg_write,
		.wb_en, .wb_reg, .wb_data,            // WB forwarding source
		.mem_res, .mem_store_data, .mem_dst,
		.mem_mem_read, .mem_mem_write, .mem_reg_write
	);

	result_stage u_result (
		.clk, .rst_n,
		.mem_res, .mem_store_data, .mem_dst,
		.mem_mem_read, .mem_mem_write, .mem_reg_write,
		.wb_en, .wb_reg, .wb_data
	);

endmodule

`default_nettype wire

// File: bench/mips_core_chk.sv
`default_nettype none

module mips_core_chk
	import mips_pkg::*;
(
	input logic     clk,
	input logic     rst_n,
	input logic     wb_en,
	input reg_idx_t wb_reg,
	input word_t    wb_data
);

	int fail_cnt = 0; // Assertion failures so far

	// --------------------
	// Writeback port rules
	// --------------------
	a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !wb_en)
		else begin
			fail_cnt = fail_cnt + 1;
			$error("wb_en high while rst_n is low");
		end

	// r0 is never a writeback target
	a_no_r0: assert property (@(posedge clk) disable iff (!rst_n) wb_en |-> wb_reg != '0)
		else begin
			fail_cnt = fail_cnt + 1;
			$error("writeback to register 0");
		end

	a_data_known: assert property (@(posedge clk) disable iff (!rst_n)
			wb_en |-> !$isunknown(wb_data))
		else begin
			fail_cnt = fail_cnt + 1;
			$error("x or z on wb_data during writeback");
		end

endmodule

`default_nettype wire

// File: bench/mips_core_tb.sv
`default_nettype none

`include "mips_config.svh"

module mips_core_tb
	import mips_pkg::*;
();

	localparam int RESET_CYCLES = 16;
	localparam int RAND_N       = 400;
	localparam int DIRECTED_MAX = 160; // Rough bound on directed slots incl. drains
	// Every random slot may carry a bubble after a load
	localparam int CYCLE_LIMIT  = RESET_CYCLES + DIRECTED_MAX + 2 * RAND_N + 50;

	logic     clk = 1'b0;
	logic     rst_n, instr_valid, flush;
	instr_t   instr;
	logic     wb_en;
	reg_idx_t wb_reg;
	word_t    wb_data;

	// Reference model state
	word_t    ref_regs [`REG_N];
	word_t    ref_mem [`DMEM_WORDS];
	logic     exp_en_q [$];    // One entry per issued slot
	reg_idx_t exp_reg_q [$];
	word_t    exp_data_q [$];

	logic       kill_pending;  // Flush level for the next slot
	logic [31:0] rng;
	logic [5:0] fn_list [10];
	int         errors, checks, test_num, tests_failed, test_err0, cycle_cnt;

	always #4 clk = ~clk;

	mips_core u_dut (
		.clk, .rst_n, .instr, .instr_valid, .flush,
		.wb_en, .wb_reg, .wb_data
	);

	bind mips_core mips_core_chk u_chk (
		.clk(clk), .rst_n(rst_n), .wb_en(wb_en), .wb_reg(wb_reg), .wb_data(wb_data)
	);

	// --------------------
	// Helpers
	// --------------------
	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic instr_t r_type(input logic [5:0] fn, input reg_idx_t rd,
			input reg_idx_t rs, input reg_idx_t rt);
		return {`OP_RTYPE, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic instr_t i_type(input logic [5:0] op, input reg_idx_t rt,
			input reg_idx_t rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// ALU rules where a is rs and b is rt or the immediate
	function automatic word_t alu_model(input logic [5:0] fn, input word_t a, input word_t b);
		case (fn)
			`FN_ADD: return a + b;
			`FN_SUB: return a - b;
			`FN_AND: return a & b;
			`FN_OR:  return a | b;
			`FN_XOR: return a ^ b;
			`FN_NOR: return ~(a | b);
			`FN_SLT: return (a < b) ? 32'd1 : 32'd0;       // Unsigned
			`FN_MUL: return a * b;                          // Low word
			`FN_DIV: return (b == '0) ? 32'hffff_ffff : a / b;
			`FN_SRA: return (b >> a[4:0]) |
				(b[31] ? ~(32'hffff_ffff >> a[4:0]) : 32'd0); // rt shifted by rs with sign fill
			default: return '0;
		endcase
	endfunction

	// Compare the writeback port with the slot issued three edges ago
	task automatic check_writeback;
		logic     e_en;
		reg_idx_t e_reg;
		word_t    e_data;
		if (exp_en_q.size() >= 3)
		begin
			e_en   = exp_en_q.pop_front();
			e_reg  = exp_reg_q.pop_front();
			e_data = exp_data_q.pop_front();
			checks++;
			assert (wb_en === e_en)
			else begin
				$display("FAILED at %0t: wb_en %b, expected %b", $time, wb_en, e_en);
				errors++;
			end
			if (e_en)
			begin
				assert (wb_reg === e_reg)
				else begin
					$display("FAILED at %0t: wb_reg %0d, expected %0d", $time, wb_reg, e_reg);
					errors++;
				end
				assert (wb_data === e_data)
				else begin
					$display("FAILED at %0t: wb_data %h, expected %h", $time, wb_data, e_data);
					errors++;
				end
			end
		end
	endtask

	// One slot per falling edge with the model updated at issue
	task automatic issue(input instr_t ins, input logic valid, input logic kill);
		reg_idx_t rs, rt, rd, e_reg;
		word_t    a, b, imm, addr, e_data;
		logic     e_en;
		@(negedge clk);
		check_writeback();
		instr        = ins;
		instr_valid  = valid;
		flush        = kill_pending; // Hits the slot now in EX
		kill_pending = kill;
		rs   = ins[25:21];
		rt   = ins[20:16];
		rd   = ins[15:11];
		imm  = {{16{ins[15]}}, ins[15:0]};
		a    = ref_regs[rs];
		b    = ref_regs[rt];
		addr = a + imm;
		e_en   = 1'b0;
		e_reg  = '0;
		e_data = '0;
		if (valid && !kill)
		begin
			case (ins[31:26])
				`OP_RTYPE:
				begin
					e_en   = 1'b1;
					e_reg  = rd;
					e_data = alu_model(ins[5:0], a, b);
				end
				`OP_ADDI:
				begin
					e_en   = 1'b1;
					e_reg  = rt;
					e_data = addr;
				end
				`OP_LW:
				begin
					e_en   = 1'b1;
					e_reg  = rt;
					e_data = ref_mem[addr[7:2]];
				end
				`OP_SW: ref_mem[addr[7:2]] = b;
				default: ;
			endcase
			if (e_en && e_reg != '0)
				ref_regs[e_reg] = e_data;
		end
		exp_en_q.push_back(e_en);
		exp_reg_q.push_back(e_reg);
		exp_data_q.push_back(e_data);
	endtask

	task automatic bubble;
		issue('0, 1'b0, 1'b0);
	endtask

	// Drain the pipe and print the test line
	task automatic end_test(input string name);
		int n_err;
		repeat (3) bubble();
		n_err = errors - test_err0;
		test_num++;
		if (n_err != 0)
			tests_failed++;
		$display("test %0d %s: %s, %0d errors, %0d checks so far", test_num, name,
			(n_err == 0) ? "ok" : "failed", n_err, checks);
		test_err0 = errors;
	endtask

	// --------------------
	// Stimulus
	// --------------------
	initial
	begin : main
		logic [31:0] r_a, r_b;
		logic [3:0]  kind;
		reg_idx_t    rs, rt, rd;
		instr_t      ins;
		int          total;
		rst_n        = 1'b0;
		instr        = '0;
		instr_valid  = 1'b0;
		flush        = 1'b0;
		kill_pending = 1'b0;
		rng          = 32'hee46_35ee;
		errors       = 0;
		checks       = 0;
		test_num     = 0;
		tests_failed = 0;
		test_err0    = 0;
		for (int i = 0; i < `REG_N; i++)
			ref_regs[i] = '0;
		for (int i = 0; i < `DMEM_WORDS; i++)
			ref_mem[i] = '0;
		fn_list = '{`FN_ADD, `FN_SUB, `FN_AND, `FN_OR, `FN_XOR,
			`FN_NOR, `FN_SLT, `FN_MUL, `FN_DIV, `FN_SRA};
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// Seed r1..r7 and read each back through add r,r0
		for (int r = 1; r < 8; r++)
			issue(i_type(`OP_ADDI, reg_idx_t'(r), 5'd0, 16'(r * 16'h2345)), 1'b1, 1'b0);
		for (int r = 1; r < 8; r++)
			issue(r_type(`FN_ADD, reg_idx_t'(r), 5'd0, reg_idx_t'(r)), 1'b1, 1'b0);
		end_test("seed_readback");

		// Every funct in both operand orders plus x/0
		issue(i_type(`OP_ADDI, 5'd1, 5'd0, 16'hff9c), 1'b1, 1'b0); // -100
		issue(i_type(`OP_ADDI, 5'd2, 5'd0, 16'd7), 1'b1, 1'b0);
		for (int k = 0; k < 10; k++)
		begin
			issue(r_type(fn_list[k], reg_idx_t'(4 + k % 4), 5'd1, 5'd2), 1'b1, 1'b0);
			issue(r_type(fn_list[k], reg_idx_t'(4 + k % 4), 5'd2, 5'd1), 1'b1, 1'b0);
		end
		issue(r_type(`FN_DIV, 5'd3, 5'd1, 5'd0), 1'b1, 1'b0);
		end_test("alu_ops");

		// Distances 1..3 on rs and then on rt
		issue(i_type(`OP_ADDI, 5'd6, 5'd0, 16'h1000), 1'b1, 1'b0);
		for (int d = 1; d <= 3; d++)
			for (int s = 0; s < 2; s++)
			begin
				issue(i_type(`OP_ADDI, 5'd1, 5'd0, 16'(16'h0100 + d * 16 + s)), 1'b1, 1'b0);
				for (int f = 1; f < d; f++)
					issue(i_type(`OP_ADDI, 5'd7, 5'd0, 16'(f)), 1'b1, 1'b0); // Filler
				if (s == 0)
					issue(r_type(`FN_ADD, 5'd2, 5'd1, 5'd6), 1'b1, 1'b0);
				else
					issue(r_type(`FN_SUB, 5'd2, 5'd6, 5'd1), 1'b1, 1'b0);
			end
		issue(r_type(`FN_ADD, 5'd3, 5'd2, 5'd2), 1'b1, 1'b0); // Both from MEM
		end_test("forwarding");

		// Store then load with forwarded store data
		issue(i_type(`OP_ADDI, 5'd1, 5'd0, 16'h0040), 1'b1, 1'b0);
		issue(i_type(`OP_ADDI, 5'd2, 5'd0, 16'h5a5a), 1'b1, 1'b0);
		issue(i_type(`OP_SW, 5'd2, 5'd1, 16'd0), 1'b1, 1'b0);
		issue(i_type(`OP_LW, 5'd3, 5'd1, 16'd0), 1'b1, 1'b0);
		bubble();
		issue(r_type(`FN_ADD, 5'd4, 5'd3, 5'd2), 1'b1, 1'b0);
		issue(i_type(`OP_ADDI, 5'd2, 5'd0, 16'hfffd), 1'b1, 1'b0);
		issue(i_type(`OP_SW, 5'd2, 5'd1, 16'd4), 1'b1, 1'b0);
		issue(i_type(`OP_LW, 5'd5, 5'd1, 16'd4), 1'b1, 1'b0);
		bubble();
		issue(i_type(`OP_LW, 5'd6, 5'd1, 16'd8), 1'b1, 1'b0); // Untouched word
		bubble();
		issue(r_type(`FN_OR, 5'd7, 5'd5, 5'd6), 1'b1, 1'b0);
		end_test("store_load");

		// Flushed and invalid slots leave no trace
		issue(i_type(`OP_ADDI, 5'd1, 5'd0, 16'd11), 1'b1, 1'b0);
		issue(i_type(`OP_ADDI, 5'd1, 5'd0, 16'd99), 1'b1, 1'b1);
		issue(i_type(`OP_ADDI, 5'd2, 5'd1, 16'd1), 1'b1, 1'b0);
		issue(i_type(`OP_ADDI, 5'd1, 5'd0, 16'd55), 1'b0, 1'b0);
		issue(r_type(`FN_ADD, 5'd3, 5'd1, 5'd0), 1'b1, 1'b0);
		issue(i_type(`OP_ADDI, 5'd4, 5'd0, 16'h0080), 1'b1, 1'b0);
		issue(i_type(`OP_SW, 5'd2, 5'd4, 16'd0), 1'b1, 1'b1);
		issue(i_type(`OP_SW, 5'd2, 5'd4, 16'd4), 1'b0, 1'b0); // Invalid store
		issue(i_type(`OP_LW, 5'd5, 5'd4, 16'd0), 1'b1, 1'b0);
		issue(i_type(`OP_LW, 5'd7, 5'd4, 16'd4), 1'b1, 1'b0);
		bubble();
		issue(r_type(`FN_ADD, 5'd6, 5'd5, 5'd1), 1'b1, 1'b0);
		end_test("flush_bubble");

		// Random mix over r1..r7
		for (int i = 0; i < RAND_N; i++)
		begin
			rng  = xorshift32(rng);
			r_a  = rng;
			rng  = xorshift32(rng);
			r_b  = rng;
			kind = r_a[27:24];
			rs   = reg_idx_t'(r_a[7:0] % 7 + 1);
			rt   = reg_idx_t'(r_a[15:8] % 7 + 1);
			rd   = reg_idx_t'(r_a[23:16] % 7 + 1);
			if (kind < 4'd10)
				ins = r_type(fn_list[kind], rd, rs, rt);
			else if (kind == 4'd12)
				ins = i_type(`OP_LW, rd, rs, r_b[31:16]);
			else if (kind == 4'd13)
				ins = i_type(`OP_SW, rt, rs, r_b[31:16]);
			else
				ins = i_type(`OP_ADDI, rd, rs, r_b[31:16]);
			issue(ins, r_b[7:4] != 4'd0, r_b[3:0] == 4'd0);
			if (kind == 4'd12)
				bubble(); // No use right after a load
		end
		end_test("random_mix");

		total = errors + u_dut.u_chk.fail_cnt;
		$display("%0d tests, %0d failed, %0d checks, %0d mismatches, %0d assertion failures",
			test_num, tests_failed, checks, errors, u_dut.u_chk.fail_cnt);
		if (total == 0 && tests_failed == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

	// --------------------
	// Watchdog
	// --------------------
	initial
	begin : watchdog
		cycle_cnt = 0;
		while (cycle_cnt < CYCLE_LIMIT)
		begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("Timeout: run did not end within %0d cycles", CYCLE_LIMIT);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
+incdir+include
rtl/mips_pkg.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/result_stage.sv
rtl/mips_core.sv
bench/mips_core_chk.sv
bench/mips_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module mips_core_tb \
	-Mdir obj_dir -o mips_core_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "Build failed, see build.log"
	exit 1
fi

./obj_dir/mips_core_sim +verilator+error+limit+100 > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
	echo "Result: fail"
	exit 1
fi

if [ $run_status -ne 0 ]; then
	echo "Simulator exited with status $run_status"
	exit 1
fi

echo "Result: pass"
exit 0
